// ==== rtl/cdcPkg.sv ====
// Shared FIFO sizes, imported by the dual-clock FIFO RTL and its testbench
`default_nettype none

package cdcPkg;

    // Width of one FIFO word
    localparam int dataWidth = 8;

    // Number of storage entries, must be a power of two
    localparam int fifoDepth = 16;

    // Storage address width
    localparam int addrWidth = $clog2(fifoDepth);

    // Pointer width, one extra bit tells laps apart
    localparam int ptrWidth = addrWidth + 1;

    // Flops in each pointer synchronizer
    localparam int syncStages = 2;

endpackage : cdcPkg

`default_nettype wire

// ==== rtl/syncChain.sv ====
// Multi-flop synchronizer that brings a Gray-coded pointer into the destination clock domain
`timescale 1ns/1ps
`default_nettype none

module syncChain (
    input  logic                        dstClk,
    input  logic                        arstN,
    input  logic [cdcPkg::ptrWidth-1:0] asyncIn,
    output logic [cdcPkg::ptrWidth-1:0] syncOut
);

    import cdcPkg::*;

    // Stage 0 samples the asynchronous input, the last stage is the stable copy
    logic [ptrWidth-1:0] stages [syncStages];

    always_ff @(posedge dstClk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < syncStages; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= asyncIn;
            for (int i = 1; i < syncStages; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // Input is Gray coded, so a capture is either the old or the new value
    assign syncOut = stages[syncStages-1];

endmodule : syncChain

`default_nettype wire

// ==== rtl/grayPtrCounter.sv ====
// Binary and Gray pointer counter with full or empty detection, one per FIFO side
`timescale 1ns/1ps
`default_nettype none

module grayPtrCounter #(
    parameter bit isFullCheck = 1'b1
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         advance,
    input  logic [cdcPkg::ptrWidth-1:0]  farGray,
    output logic                         match,
    output logic [cdcPkg::ptrWidth-1:0]  grayPtr,
    output logic [cdcPkg::ptrWidth-1:0]  binPtr,
    output logic [cdcPkg::addrWidth-1:0] addr
);

    import cdcPkg::*;

    logic                step;
    logic [ptrWidth-1:0] binNext;
    logic [ptrWidth-1:0] grayNext;
    logic [ptrWidth-1:0] farCompare;

    // Never step past full or empty
    assign step     = advance & ~match;
    assign binNext  = binPtr + ptrWidth'(step);
    assign grayNext = binNext ^ (binNext >> 1);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            binPtr  <= '0;
            grayPtr <= '0;
        end else begin
            binPtr  <= binNext;
            grayPtr <= grayNext;
        end
    end

    // Full in Gray code: top two bits inverted, the rest equal
    generate
        if (isFullCheck) begin : gFull
            assign farCompare = {~farGray[ptrWidth-1 -: 2], farGray[ptrWidth-3:0]};
        end else begin : gEmpty
            assign farCompare = farGray;
        end
    endgenerate

    assign match = (grayPtr == farCompare);

    // Storage index drops the lap bit
    assign addr = binPtr[addrWidth-1:0];

endmodule : grayPtrCounter

`default_nettype wire

// ==== rtl/fillLevel.sv ====
// Write-side fill level from the write pointer and the synchronized read pointer
`timescale 1ns/1ps
`default_nettype none

module fillLevel (
    input  logic                        w_clk,
    input  logic                        arstN,
    input  logic [cdcPkg::ptrWidth-1:0] wrBinPtr,
    input  logic [cdcPkg::ptrWidth-1:0] rdGraySync,
    output logic [cdcPkg::addrWidth:0]  level
);

    import cdcPkg::*;

    logic [ptrWidth-1:0] rdBinComb;
    logic [ptrWidth-1:0] rdBin;

    // Gray to binary, each bit is the XOR of all higher Gray bits
    always_comb begin
        rdBinComb[ptrWidth-1] = rdGraySync[ptrWidth-1];
        for (int i = ptrWidth - 2; i >= 0; i--) begin
            rdBinComb[i] = rdBinComb[i+1] ^ rdGraySync[i];
        end
    end

    // Converted read pointer held in the write domain
    // Lags by one more cycle, which only makes the level more pessimistic
    always_ff @(posedge w_clk or negedge arstN) begin
        if (!arstN) begin
            rdBin <= '0;
        end else begin
            rdBin <= rdBinComb;
        end
    end

    // Modulo difference, write side leads so it ranges 0 to fifoDepth
    assign level = wrBinPtr - rdBin;

endmodule : fillLevel

`default_nettype wire

// ==== rtl/cdcFifo.sv ====
// Dual-clock FIFO top level, carries words from the w_clk domain to the r_clk domain
`timescale 1ns/1ps
`default_nettype none

module cdcFifo (
    input  logic                         w_clk,
    input  logic                         r_clk,
    input  logic                         arstN,

    // Write side, inAck from the source, inReq means room
    input  logic                         inAck,
    input  logic [cdcPkg::dataWidth-1:0] inData,
    output logic                         inReq,
    output logic [cdcPkg::addrWidth:0]   inLevel,

    // Read side, outReq from the sink, outAck means a word is there
    input  logic                         outReq,
    output logic                         outAck,
    output logic [cdcPkg::dataWidth-1:0] outData
);

    import cdcPkg::*;

    logic                 full;
    logic                 empty;
    logic                 wrEn;
    logic                 rdEn;

    logic [ptrWidth-1:0]  wrGray;
    logic [ptrWidth-1:0]  wrBinPtr;
    logic [addrWidth-1:0] wrAddr;
    logic [ptrWidth-1:0]  wrGraySync;

    logic [ptrWidth-1:0]  rdGray;
    logic [addrWidth-1:0] rdAddr;
    logic [ptrWidth-1:0]  rdGraySync;

    logic [dataWidth-1:0] mem [fifoDepth];

    // Handshakes
    assign inReq  = ~full;
    assign outAck = ~empty;
    assign wrEn   = inAck & inReq;
    assign rdEn   = outReq & outAck;

    // Storage, written in the write domain
    always_ff @(posedge w_clk) begin
        if (wrEn) begin
            mem[wrAddr] <= inData;
        end
    end

    // Head word only shows during a read transfer
    assign outData = rdEn ? mem[rdAddr] : '0;

    // Write pointer, compared against the read pointer for full
    grayPtrCounter #(
        .isFullCheck(1'b1)
    ) wrCounter (
        .clk    (w_clk),
        .arstN  (arstN),
        .advance(wrEn),
        .farGray(rdGraySync),
        .match  (full),
        .grayPtr(wrGray),
        .binPtr (wrBinPtr),
        .addr   (wrAddr)
    );

    // Write pointer into the read domain
    syncChain wrToRdSync (
        .dstClk (r_clk),
        .arstN  (arstN),
        .asyncIn(wrGray),
        .syncOut(wrGraySync)
    );

    // Read pointer, compared against the write pointer for empty
    grayPtrCounter #(
        .isFullCheck(1'b0)
    ) rdCounter (
        .clk    (r_clk),
        .arstN  (arstN),
        .advance(rdEn),
        .farGray(wrGraySync),
        .match  (empty),
        .grayPtr(rdGray),
        .binPtr (),
        .addr   (rdAddr)
    );

    // Read pointer into the write domain
    syncChain rdToWrSync (
        .dstClk (w_clk),
        .arstN  (arstN),
        .asyncIn(rdGray),
        .syncOut(rdGraySync)
    );

    // Occupancy as seen by the writer
    fillLevel wrLevel (
        .w_clk     (w_clk),
        .arstN     (arstN),
        .wrBinPtr  (wrBinPtr),
        .rdGraySync(rdGraySync),
        .level     (inLevel)
    );

endmodule : cdcFifo

`default_nettype wire

// ==== tb/cdcFifo_asserts.sv ====
// Handshake and pointer assertions, bound into every cdcFifo instance
`timescale 1ns/1ps
`default_nettype none

module cdcFifo_asserts (
    input logic                        w_clk,
    input logic                        r_clk,
    input logic                        arstN,
    input logic                        full,
    input logic                        empty,
    input logic [cdcPkg::ptrWidth-1:0] wrGray,
    input logic [cdcPkg::ptrWidth-1:0] rdGray,
    input logic [cdcPkg::ptrWidth-1:0] rdGraySync,
    input logic [cdcPkg::addrWidth:0]  inLevel
);

    import cdcPkg::*;

    // A full FIFO keeps its write pointer, so no slot is overwritten
    noWriteWhenFull: assert property (@(posedge w_clk) disable iff (!arstN)
        full |=> $stable(wrGray))
        else $error("write pointer advanced while full");

    noReadWhenEmpty: assert property (@(posedge r_clk) disable iff (!arstN)
        empty |=> $stable(rdGray))
        else $error("read pointer advanced while empty");

    // Source Gray pointers, one bit per own clock
    wrGrayOneBit: assert property (@(posedge w_clk) disable iff (!arstN)
        $countones(wrGray ^ $past(wrGray)) <= 1)
        else $error("write Gray pointer changed by more than one bit");

    rdGrayOneBit: assert property (@(posedge r_clk) disable iff (!arstN)
        $countones(rdGray ^ $past(rdGray)) <= 1)
        else $error("read Gray pointer changed by more than one bit");

    // w_clk is the faster clock, so the synced copy also moves one bit at a time
    rdSyncOneBit: assert property (@(posedge w_clk) disable iff (!arstN)
        $countones(rdGraySync ^ $past(rdGraySync)) <= 1)
        else $error("synchronized read pointer changed by more than one bit");

    levelInRange: assert property (@(posedge w_clk) disable iff (!arstN)
        32'(inLevel) <= fifoDepth)
        else $error("inLevel above FIFO depth");

endmodule : cdcFifo_asserts

bind cdcFifo cdcFifo_asserts cdcFifoAssertsInst (
    .w_clk     (w_clk),
    .r_clk     (r_clk),
    .arstN     (arstN),
    .full      (full),
    .empty     (empty),
    .wrGray    (wrGray),
    .rdGray    (rdGray),
    .rdGraySync(rdGraySync),
    .inLevel   (inLevel)
);

`default_nettype wire

// ==== tb/cdcFifoTb.sv ====
// Directed testbench for the dual-clock FIFO, top module of the simulation build
`timescale 1ns/1ps
`default_nettype none

module cdcFifoTb;

    import cdcPkg::*;

    localparam int resetCycles   = 10;
    localparam int ackTimeout    = 10;
    localparam int streamWords   = 200;
    localparam int streamTimeout = 5000;

    logic                 w_clk = 1'b0;
    logic                 r_clk = 1'b0;
    logic                 arstN;
    logic                 inAck;
    logic [dataWidth-1:0] inData;
    logic                 inReq;
    logic [addrWidth:0]   inLevel;
    logic                 outReq;
    logic                 outAck;
    logic [dataWidth-1:0] outData;

    // Words accepted by the FIFO and not yet read, oldest first
    logic [dataWidth-1:0] model [$];

    logic [31:0] lcgState;
    int          testCount;
    int          checkCount;
    int          errorCount;
    int          testErrorStart;

    cdcFifo cdcFifo_inst (
        .w_clk  (w_clk),
        .r_clk  (r_clk),
        .arstN  (arstN),
        .inAck  (inAck),
        .inData (inData),
        .inReq  (inReq),
        .inLevel(inLevel),
        .outReq (outReq),
        .outAck (outAck),
        .outData(outData)
    );

    // Unrelated clocks, 100 ns and 130 ns
    always #50 w_clk = ~w_clk;
    always #65 r_clk = ~r_clk;

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic finishTest(input string name);
        int errors;
        errors = errorCount - testErrorStart;
        testCount++;
        if (errors == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, errors);
        end
        testErrorStart = errorCount;
    endtask

    // Source holds the word until inReq lets it through
    task automatic writeWord(input logic [dataWidth-1:0] data);
        int waited;
        waited = 0;
        @(posedge w_clk);
        #1;
        inAck  = 1'b1;
        inData = data;
        @(negedge w_clk);
        while (!inReq && waited < ackTimeout) begin
            waited++;
            @(negedge w_clk);
        end
        if (inReq) begin
            model.push_back(data);
        end else begin
            errorCount++;
            $display("Timeout at %0t ns: inReq stayed low for %0d w_clk cycles", $time, ackTimeout);
        end
        @(posedge w_clk);
        #1;
        inAck = 1'b0;
    endtask

    task automatic waitOutAck(output bit seen);
        int waited;
        waited = 0;
        @(negedge r_clk);
        while (!outAck && waited < ackTimeout) begin
            checkValue("outData", 32'(outData), 32'd0);
            waited++;
            @(negedge r_clk);
        end
        seen = outAck;
        if (!seen) begin
            errorCount++;
            $display("Timeout at %0t ns: outAck did not rise within %0d r_clk cycles",
                     $time, ackTimeout);
        end
    endtask

    task automatic readWord();
        bit                   seen;
        logic [dataWidth-1:0] expected;
        waitOutAck(seen);
        if (seen) begin
            @(posedge r_clk);
            #1;
            outReq = 1'b1;
            @(negedge r_clk);
            checkValue("outAck", 32'(outAck), 32'd1);
            if (model.size() == 0) begin
                errorCount++;
                $display("Read at %0t ns found a word that was never written", $time);
            end else begin
                expected = model.pop_front();
                checkValue("outData", 32'(outData), 32'(expected));
            end
            @(posedge r_clk);
            #1;
            outReq = 1'b0;
        end
    endtask

    task automatic testReset();
        @(negedge w_clk);
        checkValue("inReq", 32'(inReq), 32'd1);
        checkValue("inLevel", 32'(inLevel), 32'd0);
        @(negedge r_clk);
        checkValue("outAck", 32'(outAck), 32'd0);
        checkValue("outData", 32'(outData), 32'd0);
        finishTest("test 1 reset state");
    endtask

    task automatic testSingleWord();
        bit seen;
        writeWord(8'h3C);
        waitOutAck(seen);
        // Word waits while the sink does not ask
        repeat (2) begin
            @(negedge r_clk);
            checkValue("outAck", 32'(outAck), 32'd1);
            checkValue("outData", 32'(outData), 32'd0);
        end
        readWord();
        // Empty again, so asking shows nothing
        @(posedge r_clk);
        #1;
        outReq = 1'b1;
        @(negedge r_clk);
        checkValue("outAck", 32'(outAck), 32'd0);
        checkValue("outData", 32'(outData), 32'd0);
        @(posedge r_clk);
        #1;
        outReq = 1'b0;
        finishTest("test 2 single word");
    endtask

    task automatic testFillAndDrain();
        for (int i = 0; i < fifoDepth; i++) begin
            writeWord(dataWidth'(i * 7 + 64));
            // Level counts the write in the same cycle
            @(negedge w_clk);
            checkValue("inLevel", 32'(inLevel), 32'(i + 1));
        end
        checkValue("inReq", 32'(inReq), 32'd0);
        // Seventeenth word is offered but must not get in
        @(posedge w_clk);
        #1;
        inAck  = 1'b1;
        inData = 8'hEE;
        repeat (4) begin
            @(negedge w_clk);
            checkValue("inReq", 32'(inReq), 32'd0);
            checkValue("inLevel", 32'(inLevel), 32'(fifoDepth));
        end
        @(posedge w_clk);
        #1;
        inAck = 1'b0;
        repeat (fifoDepth) begin
            readWord();
        end
        repeat (4) begin
            @(negedge r_clk);
            checkValue("outAck", 32'(outAck), 32'd0);
        end
        checkValue("model size", 32'(model.size()), 32'd0);
        finishTest("test 3 fill and drain");
    endtask

    task automatic streamWriter(input int count);
        int          sent;
        int          cycles;
        bit          accepted;
        logic [31:0] rnd;
        sent     = 0;
        cycles   = 0;
        accepted = 1'b0;
        while (sent < count && cycles < streamTimeout) begin
            @(posedge w_clk);
            #1;
            if (accepted) begin
                inAck = 1'b0;
            end
            rnd = nextRandom();
            // New word in about three cycles of four
            if (!inAck && rnd[31:30] != 2'b00) begin
                inAck  = 1'b1;
                inData = rnd[23:16];
            end
            @(negedge w_clk);
            accepted = inAck && inReq;
            if (accepted) begin
                model.push_back(inData);
                sent++;
            end
            cycles++;
        end
        @(posedge w_clk);
        #1;
        inAck = 1'b0;
        if (sent < count) begin
            errorCount++;
            $display("Timeout at %0t ns: only %0d of %0d words were accepted", $time, sent, count);
        end
    endtask

    task automatic streamReader(input int count);
        int                   received;
        int                   cycles;
        logic [31:0]          rnd;
        logic [dataWidth-1:0] expected;
        received = 0;
        cycles   = 0;
        while (received < count && cycles < streamTimeout) begin
            @(posedge r_clk);
            #1;
            rnd    = nextRandom();
            outReq = (rnd[31:30] != 2'b00);
            @(negedge r_clk);
            if (outReq && outAck) begin
                if (model.size() == 0) begin
                    errorCount++;
                    $display("Read at %0t ns found a word that was never written", $time);
                end else begin
                    expected = model.pop_front();
                    checkValue("outData", 32'(outData), 32'(expected));
                end
                received++;
            end else begin
                checkValue("outData", 32'(outData), 32'd0);
            end
            cycles++;
        end
        @(posedge r_clk);
        #1;
        outReq = 1'b0;
        if (received < count) begin
            errorCount++;
            $display("Timeout at %0t ns: only %0d of %0d words were read", $time, received, count);
        end
    endtask

    task automatic testRandomTraffic();
        fork
            streamWriter(streamWords);
            streamReader(streamWords);
        join
        checkValue("model size", 32'(model.size()), 32'd0);
        finishTest("test 4 random traffic");
    endtask

    task automatic testDrainedState();
        int waited;
        waited = 0;
        @(negedge w_clk);
        while (!(inLevel == '0 && inReq) && waited < ackTimeout) begin
            waited++;
            @(negedge w_clk);
        end
        if (!(inLevel == '0 && inReq)) begin
            errorCount++;
            $display("Timeout at %0t ns: write side did not see the FIFO empty", $time);
        end
        checkValue("inLevel", 32'(inLevel), 32'd0);
        checkValue("inReq", 32'(inReq), 32'd1);
        @(negedge r_clk);
        checkValue("outAck", 32'(outAck), 32'd0);
        checkValue("outData", 32'(outData), 32'd0);
        finishTest("test 5 drained state");
    endtask

    initial begin
        arstN          = 1'b0;
        inAck          = 1'b0;
        inData         = '0;
        outReq         = 1'b0;
        lcgState       = 32'd80196;
        testCount      = 0;
        checkCount     = 0;
        errorCount     = 0;
        testErrorStart = 0;

        repeat (resetCycles) @(posedge w_clk);
        #1;
        arstN = 1'b1;

        testReset();
        testSingleWord();
        testFillAndDrain();
        testRandomTraffic();
        testDrainedState();

        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : cdcFifoTb

`default_nettype wire

// ==== files.f ====
rtl/cdcPkg.sv
rtl/syncChain.sv
rtl/grayPtrCounter.sv
rtl/fillLevel.sv
rtl/cdcFifo.sv
tb/cdcFifo_asserts.sv
tb/cdcFifoTb.sv

// ==== Makefile ====
# Verilator build and run for the dual-clock FIFO testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := cdcFifoTb
FILELIST  := files.f

OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
FAILMSG   := TEST FAILED
PASSMSG   := TEST OK
SOURCES   := $(wildcard rtl/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# A run that stops before the final report counts as a failure too
run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
